// File: src/rv_isa_pkg.sv
//******************************
// RV32I subset encodings
//******************************

package rv_isa_pkg;

    // instruction field types
    typedef logic [4:0] reg_idx_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // funct3 / funct7 selectors
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_SW  = 3'b010;
    localparam funct7_t F7_SUB = 7'b0100000;

    // multi-cycle core sequencing
    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_TRAP
    } core_state_e;

endpackage

// File: src/mem_map_pkg.sv
//******************************
// Memory map
//******************************

package mem_map_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // 1024 words of RAM starting at address zero
    localparam int RAM_ADDR_WIDTH = 10;
    localparam int RAM_WORDS      = 1 << RAM_ADDR_WIDTH;

    typedef logic [RAM_ADDR_WIDTH-1:0] ram_idx_t;

    // first fetch after enable
    localparam addr_t BOOT_ADDR = 32'h0000_0000;

    // pseudo peripherals
    localparam addr_t STDOUT_ADDR = 32'h1000_0000;
    localparam addr_t RESULT_ADDR = 32'h2000_0000;
    localparam addr_t EXIT_ADDR   = 32'h2000_0004;

endpackage

// File: src/rv_mini_core.sv
//******************************
// Multi-cycle RV32I subset core
//******************************
`timescale 1ns/1ps

module rv_mini_core
    import rv_isa_pkg::*;
    import mem_map_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    input  logic  fetch_enable_i,

    // instruction fetch
    output logic  instr_req_o,
    output addr_t instr_addr_o,
    input  logic  instr_rvalid_i,
    input  word_t instr_rdata_i,

    // data access
    output logic  data_req_o,
    output logic  data_we_o,
    output addr_t data_addr_o,
    output word_t data_wdata_o,
    input  logic  data_rvalid_i,
    input  word_t data_rdata_i,

    output logic  trap_o
);

    core_state_e state_q;
    addr_t       pc_q;
    addr_t       pc_plus4;
    addr_t       pc_next;

    // x1..x31, x0 is never stored
    word_t rf [1:31];

    // latched instruction and operands
    word_t instr_q;
    word_t rs1_val_q;
    word_t rs2_val_q;

    // fields of the word arriving from the fetch port
    opcode_t  fetch_opcode;
    funct3_t  fetch_funct3;
    reg_idx_t fetch_rs1;
    reg_idx_t fetch_rs2;

    // fields of the latched instruction
    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    reg_idx_t rd;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    logic  is_load;
    logic  is_store;
    logic  is_mem;
    logic  branch_taken;
    logic  rf_we;
    word_t rf_wdata;
    word_t exec_result;

    function automatic word_t rf_read(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    function automatic logic is_supported(opcode_t opc, funct3_t f3);
        logic ok;
        case (opc)
            OPC_LUI, OPC_OPIMM, OPC_OP, OPC_JAL: ok = 1'b1;
            OPC_BRANCH: ok = (f3 == F3_BEQ) || (f3 == F3_BNE);
            OPC_LOAD:   ok = (f3 == F3_LW);
            OPC_STORE:  ok = (f3 == F3_SW);
            default:    ok = 1'b0;
        endcase
        return ok;
    endfunction

    assign fetch_opcode = instr_rdata_i[6:0];
    assign fetch_funct3 = instr_rdata_i[14:12];
    assign fetch_rs1    = instr_rdata_i[19:15];
    assign fetch_rs2    = instr_rdata_i[24:20];

    assign opcode = instr_q[6:0];
    assign rd     = instr_q[11:7];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    // immediate formats
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                    instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                    instr_q[20], instr_q[30:21], 1'b0};

    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_mem   = is_load || is_store;

    assign branch_taken = ((funct3 == F3_BEQ) && (rs1_val_q == rs2_val_q)) ||
                          ((funct3 == F3_BNE) && (rs1_val_q != rs2_val_q));

    assign pc_plus4 = pc_q + 32'd4;

    // execute stage result and next pc
    always_comb begin
        exec_result = '0;
        pc_next     = pc_plus4;
        case (opcode)
            OPC_LUI:   exec_result = imm_u;
            OPC_OPIMM: exec_result = rs1_val_q + imm_i;
            OPC_OP: begin
                if (funct7 == F7_SUB) begin
                    exec_result = rs1_val_q - rs2_val_q;
                end else begin
                    exec_result = rs1_val_q + rs2_val_q;
                end
            end
            OPC_BRANCH: begin
                if (branch_taken) begin
                    pc_next = pc_q + imm_b;
                end
            end
            OPC_JAL: begin
                exec_result = pc_plus4;
                pc_next     = pc_q + imm_j;
            end
            default: exec_result = '0;
        endcase
    end

    // branches and stores never write back
    assign rf_we = ((state_q == S_EXEC) && !is_mem && (opcode != OPC_BRANCH)) ||
                   ((state_q == S_MEM) && is_load && data_rvalid_i);
    assign rf_wdata = (state_q == S_MEM) ? data_rdata_i : exec_result;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            pc_q    <= BOOT_ADDR;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fetch_enable_i) begin
                        pc_q    <= BOOT_ADDR;
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH: state_q <= S_DECODE;
                S_DECODE: begin
                    if (instr_rvalid_i) begin
                        if (is_supported(fetch_opcode, fetch_funct3)) begin
                            state_q <= S_EXEC;
                        end else begin
                            state_q <= S_TRAP;
                        end
                    end
                end
                S_EXEC: begin
                    if (is_mem) begin
                        state_q <= S_MEM;
                    end else begin
                        pc_q    <= pc_next;
                        state_q <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (data_rvalid_i) begin
                        pc_q    <= pc_plus4;
                        state_q <= S_FETCH;
                    end
                end
                // stuck until reset
                S_TRAP:  state_q <= S_TRAP;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // instruction latch, operand read and register write back
    always_ff @(posedge clk_i) begin
        if ((state_q == S_DECODE) && instr_rvalid_i) begin
            instr_q   <= instr_rdata_i;
            rs1_val_q <= rf_read(fetch_rs1);
            rs2_val_q <= rf_read(fetch_rs2);
        end
        if (rf_we && (rd != '0)) begin
            rf[rd] <= rf_wdata;
        end
    end

    assign instr_req_o  = (state_q == S_FETCH);
    assign instr_addr_o = pc_q;

    assign data_req_o   = (state_q == S_EXEC) && is_mem;
    assign data_we_o    = (state_q == S_EXEC) && is_store;
    assign data_addr_o  = rs1_val_q + (is_store ? imm_s : imm_i);
    assign data_wdata_o = rs2_val_q;

    assign trap_o = (state_q == S_TRAP);

endmodule

// File: src/mm_ram.sv
//******************************
// RAM and pseudo peripherals
//******************************
`timescale 1ns/1ps

module mm_ram
    import mem_map_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // instruction read port
    input  logic        instr_req_i,
    input  addr_t       instr_addr_i,
    output logic        instr_rvalid_o,
    output word_t       instr_rdata_o,

    // data port
    input  logic        data_req_i,
    input  logic        data_we_i,
    input  addr_t       data_addr_i,
    input  word_t       data_wdata_i,
    output logic        data_rvalid_o,
    output word_t       data_rdata_o,

    // boot loader
    input  logic        load_we_i,
    input  ram_idx_t    load_idx_i,
    input  word_t       load_data_i,

    // peripheral outputs
    output logic        stdout_valid_o,
    output logic [7:0]  stdout_char_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic        exit_valid_o,
    output word_t       exit_value_o
);

    word_t mem [RAM_WORDS];

    ram_idx_t instr_idx;
    ram_idx_t data_idx;

    logic  is_ram;
    logic  is_stdout;
    logic  is_result;
    logic  is_exit;
    logic  data_wr;
    word_t rd_word;

    // byte address to word index
    assign instr_idx = instr_addr_i[RAM_ADDR_WIDTH+1:2];
    assign data_idx  = data_addr_i[RAM_ADDR_WIDTH+1:2];

    // address decode of the data port
    assign is_ram    = (data_addr_i[31:RAM_ADDR_WIDTH+2] == '0);
    assign is_stdout = (data_addr_i == STDOUT_ADDR);
    assign is_result = (data_addr_i == RESULT_ADDR);
    assign is_exit   = (data_addr_i == EXIT_ADDR);

    assign data_wr = data_req_i && data_we_i;

    // result and exit ports read back their current state
    always_comb begin
        rd_word = '0;
        if (is_ram) begin
            rd_word = mem[data_idx];
        end else if (is_result) begin
            rd_word = {30'b0, tests_failed_o, tests_passed_o};
        end else if (is_exit) begin
            rd_word = exit_value_o;
        end
    end

    // loader wins over a core write on the same cycle
    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_idx_i] <= load_data_i;
        end else if (data_wr && is_ram) begin
            mem[data_idx] <= data_wdata_i;
        end
    end

    // read data, one cycle after the request
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            instr_rdata_o <= mem[instr_idx];
        end
        if (data_req_i) begin
            data_rdata_o <= data_we_i ? '0 : rd_word;
        end
        if (data_wr && is_stdout) begin
            stdout_char_o <= data_wdata_i[7:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            stdout_valid_o <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
            stdout_valid_o <= data_wr && is_stdout;

            // sticky result flags
            if (data_wr && is_result) begin
                if (data_wdata_i == '0) begin
                    tests_passed_o <= 1'b1;
                end else begin
                    tests_failed_o <= 1'b1;
                end
            end

            if (data_wr && is_exit) begin
                exit_valid_o <= 1'b1;
                exit_value_o <= data_wdata_i;
            end
        end
    end

endmodule

// File: src/riscv_wrapper.sv
//******************************
// Core and memory top level
//******************************
`timescale 1ns/1ps

module riscv_wrapper
    import mem_map_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       fetch_enable_i,

    // program load while fetch is disabled
    input  logic       load_we_i,
    input  ram_idx_t   load_idx_i,
    input  word_t      load_data_i,

    output logic       stdout_valid_o,
    output logic [7:0] stdout_char_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output word_t      exit_value_o,
    output logic       trap_o
);

    // core to memory
    logic  instr_req;
    addr_t instr_addr;
    logic  instr_rvalid;
    word_t instr_rdata;

    logic  data_req;
    logic  data_we;
    addr_t data_addr;
    word_t data_wdata;
    logic  data_rvalid;
    word_t data_rdata;

    rv_mini_core riscv_core_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req      ),
        .instr_addr_o   ( instr_addr     ),
        .instr_rvalid_i ( instr_rvalid   ),
        .instr_rdata_i  ( instr_rdata    ),
        .data_req_o     ( data_req       ),
        .data_we_o      ( data_we        ),
        .data_addr_o    ( data_addr      ),
        .data_wdata_o   ( data_wdata     ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_rdata_i   ( data_rdata     ),
        .trap_o         ( trap_o         )
    );

    // RAM plus stdout, result and exit ports
    mm_ram ram_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .instr_req_i    ( instr_req      ),
        .instr_addr_i   ( instr_addr     ),
        .instr_rvalid_o ( instr_rvalid   ),
        .instr_rdata_o  ( instr_rdata    ),
        .data_req_i     ( data_req       ),
        .data_we_i      ( data_we        ),
        .data_addr_i    ( data_addr      ),
        .data_wdata_i   ( data_wdata     ),
        .data_rvalid_o  ( data_rvalid    ),
        .data_rdata_o   ( data_rdata     ),
        .load_we_i      ( load_we_i      ),
        .load_idx_i     ( load_idx_i     ),
        .load_data_i    ( load_data_i    ),
        .stdout_valid_o ( stdout_valid_o ),
        .stdout_char_o  ( stdout_char_o  ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

// File: testbench/tb_riscv_wrapper.sv
//******************************
// riscv_wrapper testbench
//******************************
`timescale 1ns/1ps

module tb_riscv_wrapper
    import rv_isa_pkg::*;
    import mem_map_pkg::*;
();

    localparam string DATA_FILE          = "testbench/riscv_testdata.txt";
    localparam int    CYCLES_PER_PROGRAM = 4000;

    // expected outcome codes of an R record
    localparam int RES_EXIT = 0;
    localparam int RES_PASS = 1;
    localparam int RES_FAIL = 2;
    localparam int RES_TRAP = 3;

    logic       clk;
    logic       rst_n;
    logic       fetch_enable;
    logic       load_we;
    ram_idx_t   load_idx;
    word_t      load_data;
    logic       stdout_valid;
    logic [7:0] stdout_char;
    logic       tests_passed;
    logic       tests_failed;
    logic       exit_valid;
    word_t      exit_value;
    logic       trap;

    int errors          = 0;
    int checks          = 0;
    int program_count   = 0;
    int watchdog_cycles = 0;

    logic [7:0] exp_chars [$];
    logic [7:0] got_chars [$];
    word_t      exp_exit;
    int         exp_result;

    riscv_wrapper i_dut (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .load_we_i      ( load_we      ),
        .load_idx_i     ( load_idx     ),
        .load_data_i    ( load_data    ),
        .stdout_valid_o ( stdout_valid ),
        .stdout_char_o  ( stdout_char  ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   ),
        .trap_o         ( trap         )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // limit grows with the number of programs in the data file
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: programs did not finish within %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    // collect every character strobe of the running program
    always @(negedge clk) begin
        if (rst_n && stdout_valid) begin
            got_chars.push_back(stdout_char);
        end
    end

    task automatic check_value(input string name, input word_t exp, input word_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("FAIL %s exp %h got %h", name, exp, got);
        end
    endtask

    // flags, strobes and trap while the core is idle
    task automatic check_quiet();
        check_value("stdout_valid_o", 32'd0, 32'(stdout_valid));
        check_value("tests_passed_o", 32'd0, 32'(tests_passed));
        check_value("tests_failed_o", 32'd0, 32'(tests_failed));
        check_value("exit_valid_o", 32'd0, 32'(exit_valid));
        check_value("trap_o", 32'd0, 32'(trap));
    endtask

    task automatic read_record(input int fd, output bit ok, output logic [7:0] kind,
                               output word_t a, output word_t b);
        int                 code;
        logic [8*128-1:0]   rest;
        ok   = 1'b1;
        a    = '0;
        b    = '0;
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
            ok = 1'b0;
        end else if (kind == "#") begin
            code = $fgets(rest, fd);
        end else if (kind == "P") begin
            code = $fscanf(fd, "%h %h", a, b);
        end else if ((kind == "C") || (kind == "E") || (kind == "R")) begin
            code = $fscanf(fd, "%h", a);
        end
    endtask

    task automatic count_programs(output int n);
        int         fd;
        bit         ok;
        logic [7:0] kind;
        word_t      a;
        word_t      b;
        n  = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (ok) begin
                read_record(fd, ok, kind, a, b);
                if (ok && (kind == "G")) begin
                    n++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n        <= 1'b0;
        fetch_enable <= 1'b0;
        load_we      <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic load_word(input word_t idx, input word_t data);
        @(posedge clk);
        load_we   <= 1'b1;
        load_idx  <= idx[RAM_ADDR_WIDTH-1:0];
        load_data <= data;
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic run_program(input int num);
        core_state_e state;
        int          i;
        got_chars.delete();
        @(posedge clk);
        fetch_enable <= 1'b1;
        @(negedge clk);
        while (!(exit_valid || trap)) begin
            @(negedge clk);
        end
        // programs end in a jump to self, so nothing may change from here on
        repeat (8) @(negedge clk);
        state = i_dut.riscv_core_i.state_q;
        $display("program %0d done, core in %s, %0d stdout chars",
                 num, state.name(), got_chars.size());

        check_value("stdout_valid_o count", 32'(exp_chars.size()), 32'(got_chars.size()));
        for (i = 0; (i < exp_chars.size()) && (i < got_chars.size()); i++) begin
            check_value("stdout_char_o", 32'(exp_chars[i]), 32'(got_chars[i]));
        end
        check_value("trap_o", 32'(exp_result == RES_TRAP), 32'(trap));
        check_value("exit_valid_o", 32'(exp_result != RES_TRAP), 32'(exit_valid));
        if (exp_result != RES_TRAP) begin
            check_value("exit_value_o", exp_exit, exit_value);
        end
        check_value("tests_passed_o", 32'(exp_result == RES_PASS), 32'(tests_passed));
        check_value("tests_failed_o", 32'(exp_result == RES_FAIL), 32'(tests_failed));
    endtask

    initial begin
        bit         ok;
        logic [7:0] kind;
        word_t      a;
        word_t      b;
        int         fd;
        int         num;
        rst_n        <= 1'b0;
        fetch_enable <= 1'b0;
        load_we      <= 1'b0;
        load_idx     <= '0;
        load_data    <= '0;
        exp_exit     = '0;
        exp_result   = RES_EXIT;
        num          = 0;

        count_programs(program_count);
        if (program_count == 0) begin
            errors++;
            $display("no programs found in %s", DATA_FILE);
        end else begin
            watchdog_cycles = program_count * CYCLES_PER_PROGRAM;
            fd = $fopen(DATA_FILE, "r");
            apply_reset();
            @(negedge clk);
            check_quiet();
            ok = 1'b1;
            while (ok) begin
                read_record(fd, ok, kind, a, b);
                if (ok) begin
                    case (kind)
                        "#": ;
                        "P": begin
                            load_word(a, b);
                            @(negedge clk);
                            check_quiet();
                        end
                        "C": exp_chars.push_back(a[7:0]);
                        "E": exp_exit = a;
                        "R": exp_result = int'(a);
                        "G": begin
                            num++;
                            run_program(num);
                            exp_chars.delete();
                            exp_exit   = '0;
                            exp_result = RES_EXIT;
                            apply_reset();
                            @(negedge clk);
                            check_quiet();
                        end
                        default: begin
                            errors++;
                            $display("unknown record type %c in the data file", kind);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("programs: %0d, checks: %0d, errors: %0d", num, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/riscv_testdata.txt
# records: P <word index> <word>, C <char>, E <exit value>, R <result>, G runs the program
# values in hex; R is 0 for exit only, 1 passed, 2 failed, 3 trap
# arithmetic with lui, addi, add, sub and a write to x0
P 000 123450b7  P 001 67800113  P 002 002081b3  P 003 00500013
P 004 01000213  P 005 404181b3  P 006 000181b3  P 007 200002b7
P 008 0032a223  P 009 0000006f
E 12345668
R 0
G
# string through RAM with sw and lw, then a bne loop to stdout
P 000 20000093  P 001 04800113  P 002 0020a023  P 003 06900113
P 004 0020a223  P 005 02100113  P 006 0020a423  P 007 0000a623
P 008 100001b7  P 009 0000a203  P 00a 0041a023  P 00b 00408093
P 00c 0000a203  P 00d fe021ae3  P 00e 200002b7  P 00f 0012a223
P 010 0000006f
C 48  C 69  C 21
E 0000020c
R 0
G
# zero to the result port
P 000 200002b7  P 001 0002a023  P 002 0002a223  P 003 0000006f
E 00000000
R 1
G
# nonzero to the result port
P 000 200002b7  P 001 0052a023  P 002 0052a223  P 003 0000006f
E 20000000
R 2
G
# fence is unsupported, the stdout write after it must not run
P 000 04100093  P 001 0000000f  P 002 100001b7  P 003 0011a023
R 3
G
# sw and lw on an unmapped address
P 000 300000b7  P 001 05500113  P 002 0020a023  P 003 07f00193
P 004 0080a183  P 005 200002b7  P 006 0032a223  P 007 0000006f
E 00000000
R 0
G

// File: flist.f
src/rv_isa_pkg.sv
src/mem_map_pkg.sv
src/rv_mini_core.sv
src/mm_ram.sv
src/riscv_wrapper.sv
testbench/tb_riscv_wrapper.sv

// File: Makefile
# Verilator build and run of the riscv_wrapper testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_wrapper
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)
